/* build.f */
logic/key_panel_pkg.sv
logic/key_if.sv
logic/key_debounce.sv
logic/key_event_encoder.sv
logic/event_fifo.sv
logic/panel_wb_regs.sv
logic/key_panel_top.sv
test/tb_key_panel.sv

/* logic/event_fifo.sv */
/*
 * key event FIFO: circular buffer with occupancy count,
 * push when full and pop when empty are ignored
 */

`timescale 1ns/1ps

module event_fifo
    import key_panel_pkg::*;
#(
    parameter int FIFO_DEPTH = 8 // power of two
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  key_event_t                  push_data,
    input  logic                        pop,
    output key_event_t                  head,
    output logic                        full,
    output logic                        empty,
    output logic [$clog2(FIFO_DEPTH):0] count
);

    localparam int AW = $clog2(FIFO_DEPTH);

    key_event_t    mem [FIFO_DEPTH]; // storage, no reset
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign full    = (count == (AW + 1)'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign head    = mem[rd_ptr]; // visible the clock after the push

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // ------------------------------------------------------------
    // pointers wrap on their own, depth is a power of two
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or both
            endcase
        end
    end

endmodule

/* logic/key_debounce.sv */
/*
 * key debouncer: two-stage synchronizer, shared settle counter,
 * debounced level, press/release pulses and toggle state
 */

`timescale 1ns/1ps

module key_debounce #(
    parameter int N_KEYS          = 4,
    parameter int DEBOUNCE_CYCLES = 240000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [N_KEYS-1:0] key_n, // raw, active low
    key_if.src                keys
);

    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic [N_KEYS-1:0] sync_meta; // first flop, may go metastable
    logic [N_KEYS-1:0] sync_q;    // synchronized input
    logic [N_KEYS-1:0] sync_d;    // one clock older, for change detect
    logic              change;
    logic [CNT_W-1:0]  cnt;
    logic              settled;
    logic [N_KEYS-1:0] level_q;
    logic [N_KEYS-1:0] level_d;
    logic [N_KEYS-1:0] toggle_q;

    // ------------------------------------------------------------
    // input synchronizer
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta <= '1; // idle lines sit high
            sync_q    <= '1;
            sync_d    <= '1;
        end else begin
            sync_meta <= key_n;
            sync_q    <= sync_meta;
            sync_d    <= sync_q;
        end
    end

    assign change = (sync_q != sync_d); // any key moved

    // ------------------------------------------------------------
    // shared settle counter, saturates at the terminal value
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (change) begin
            cnt <= '0;           // restart on any bounce
        end else if (cnt != CNT_LAST) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign settled = (cnt == CNT_LAST);

    // level, its delayed copy and the toggle latch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q  <= '0;
            level_d  <= '0;
            toggle_q <= '0;
        end else begin
            if (settled)
                level_q <= ~sync_d; // all keys sampled together, pressed = 1
            level_d  <= level_q;
            toggle_q <= toggle_q ^ keys.press; // flip on press pulse
        end
    end

    assign keys.level  = level_q;
    assign keys.press  = level_q & ~level_d;  // rising level
    assign keys.rel    = ~level_q & level_d;  // falling level
    assign keys.toggle = toggle_q;

endmodule

/* logic/key_event_encoder.sv */
/*
 * key event encoder: per-key pending press/release bits,
 * lowest-index pick, one FIFO push per clock, overflow pulse
 */

`timescale 1ns/1ps

module key_event_encoder
    import key_panel_pkg::*;
#(
    parameter int N_KEYS = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    key_if.evt         keys,
    output logic       push,
    output key_event_t push_data,
    input  logic       full,
    output logic       overflow
);

    logic [N_KEYS-1:0]    pend_press; // press seen, not queued yet
    logic [N_KEYS-1:0]    pend_rel;   // release seen, not queued yet
    logic                 sel_valid;
    logic                 sel_press;
    logic [KEY_IDX_W-1:0] sel_idx;
    logic [N_KEYS-1:0]    sel_onehot;
    logic [N_KEYS-1:0]    clr_press;
    logic [N_KEYS-1:0]    clr_rel;
    logic [N_KEYS-1:0]    lost;

    // ------------------------------------------------------------
    // priority pick, lowest index wins, press before release
    // ------------------------------------------------------------
    always_comb begin
        sel_idx   = '0;
        sel_press = 1'b0;
        // walk downwards so the last hit is the lowest index
        for (int i = N_KEYS - 1; i >= 0; i--) begin
            if (pend_rel[i]) begin
                sel_idx   = KEY_IDX_W'(i);
                sel_press = 1'b0;
            end
            if (pend_press[i]) begin // press overrides release at same key
                sel_idx   = KEY_IDX_W'(i);
                sel_press = 1'b1;
            end
        end
    end

    assign sel_valid  = |{pend_press, pend_rel};
    assign push       = sel_valid & ~full; // back-pressure just waits
    assign sel_onehot = N_KEYS'(1) << sel_idx;
    assign clr_press  = (push &&  sel_press) ? sel_onehot : '0;
    assign clr_rel    = (push && !sel_press) ? sel_onehot : '0;

    always_comb begin
        push_data.pressed = sel_press;
        push_data.idx     = sel_idx;
    end

    // new pulse on a bit that stays pending this clock is dropped
    assign lost = (keys.press & pend_press & ~clr_press)
                | (keys.rel   & pend_rel   & ~clr_rel);

    // ------------------------------------------------------------
    // pending bits and overflow pulse
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_press <= '0;
            pend_rel   <= '0;
            overflow   <= 1'b0;
        end else begin
            pend_press <= (pend_press & ~clr_press) | keys.press;
            pend_rel   <= (pend_rel   & ~clr_rel)   | keys.rel;
            overflow   <= |lost; // one clock per loss
        end
    end

endmodule

/* logic/key_if.sv */
/*
 * debounced key bundle: level, edge pulses and toggle state
 */

`timescale 1ns/1ps

interface key_if #(
    parameter int N_KEYS = 4
);
    logic [N_KEYS-1:0] level;  // 1 = held down
    logic [N_KEYS-1:0] press;  // one clock on each press
    logic [N_KEYS-1:0] rel;    // one clock on each release
    logic [N_KEYS-1:0] toggle; // flips on every press

    // debouncer drives everything
    modport src  (output level, press, rel, toggle);

    // event encoder only needs the pulses
    modport evt  (input press, rel);

    // register block reads the steady state
    modport regs (input level, toggle);

endinterface

/* logic/key_panel_pkg.sv */
/*
 * key panel shared definitions: key limits, event record,
 * register word addresses and event read layout
 */

package key_panel_pkg;

    // ------------------------------------------------------------
    // key limits
    // ------------------------------------------------------------
    localparam int MAX_KEYS  = 16;               // upper bound for N_KEYS
    localparam int KEY_IDX_W = $clog2(MAX_KEYS); // 4 bits of key index

    // ------------------------------------------------------------
    // event record, as queued in the event FIFO
    // ------------------------------------------------------------
    typedef struct packed {
        logic                 pressed; // 1 = press, 0 = release
        logic [KEY_IDX_W-1:0] idx;     // key number
    } key_event_t;

    // ------------------------------------------------------------
    // register map, word addresses on wb_adr
    // ------------------------------------------------------------
    localparam logic [2:0] REG_STATE  = 3'd0; // debounced levels, ro
    localparam logic [2:0] REG_TOGGLE = 3'd1; // toggle states, ro
    localparam logic [2:0] REG_EVENT  = 3'd2; // head event, read pops
    localparam logic [2:0] REG_STATUS = 3'd3; // count + sticky overflow
    localparam logic [2:0] REG_IRQ_EN = 3'd4; // bit 0 enables irq

    // event read word layout
    localparam int EVENT_VALID_BIT   = 31; // set when a real event came back
    localparam int EVENT_PRESSED_BIT = 8;  // press/release flag

    // status word layout
    localparam int STATUS_OVF_BIT = 16; // sticky overflow, write 1 clears

endpackage

/* logic/key_panel_top.sv */
/*
 * key panel top: debouncer, event encoder, event FIFO and
 * Wishbone register block behind plain ports
 */

`timescale 1ns/1ps

module key_panel_top
    import key_panel_pkg::*;
#(
    parameter int N_KEYS          = 4,      // 1 .. MAX_KEYS
    parameter int DEBOUNCE_CYCLES = 240000, // settle time in clocks
    parameter int FIFO_DEPTH      = 8       // power of two
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [N_KEYS-1:0] key_n,
    // wishbone classic slave
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [2:0]        wb_adr,
    input  logic [31:0]       wb_dat_i,
    input  logic [3:0]        wb_sel,
    output logic [31:0]       wb_dat_o,
    output logic              wb_ack,
    output logic              irq
);

    // ------------------------------------------------------------
    // internal wiring
    // ------------------------------------------------------------
    key_if #(.N_KEYS(N_KEYS)) keys ();

    logic                        push;
    key_event_t                  push_data;
    logic                        pop;
    key_event_t                  head;
    logic                        full;
    logic                        empty;
    logic [$clog2(FIFO_DEPTH):0] count;
    logic                        overflow; // one clock per lost event

    key_debounce #(
        .N_KEYS          (N_KEYS),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_debounce (
        .clk   (clk),
        .rst_n (rst_n),
        .key_n (key_n),
        .keys  (keys.src)
    );

    key_event_encoder #(.N_KEYS(N_KEYS)) u_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .keys      (keys.evt),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .overflow  (overflow)
    );

    event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .full      (full),
        .empty     (empty),
        .count     (count)
    );

    panel_wb_regs #(
        .N_KEYS     (N_KEYS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_sel   (wb_sel),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .keys     (keys.regs),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .count    (count),
        .overflow (overflow),
        .irq      (irq)
    );

endmodule

/* logic/panel_wb_regs.sv */
/*
 * Wishbone classic slave for the key panel: register decode,
 * event pop on read, sticky overflow and level interrupt
 */

`timescale 1ns/1ps

module panel_wb_regs
    import key_panel_pkg::*;
#(
    parameter int N_KEYS     = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // wishbone classic slave
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [2:0]                  wb_adr,
    input  logic [31:0]                 wb_dat_i,
    input  logic [3:0]                  wb_sel,
    output logic [31:0]                 wb_dat_o,
    output logic                        wb_ack,
    // key state
    key_if.regs                         keys,
    // event FIFO side
    output logic                        pop,
    input  key_event_t                  head,
    input  logic                        empty,
    input  logic [$clog2(FIFO_DEPTH):0] count,
    input  logic                        overflow,
    output logic                        irq
);

    logic        req;       // new request, not yet acked
    logic        wr_stb;
    logic        ovf_clr;
    logic        ovf_sticky;
    logic        irq_en;
    logic        pop_q;     // event read decided at request time
    logic [31:0] rdata;

    assign req     = wb_cyc & wb_stb & ~wb_ack; // ack drops between cycles
    assign wr_stb  = req & wb_we;
    assign ovf_clr = wr_stb && (wb_adr == REG_STATUS) && wb_sel[2]
                     && wb_dat_i[STATUS_OVF_BIT];

    // ------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------
    always_comb begin
        rdata = '0;
        case (wb_adr)
            REG_STATE:  rdata[N_KEYS-1:0] = keys.level;
            REG_TOGGLE: rdata[N_KEYS-1:0] = keys.toggle;
            REG_EVENT: begin
                if (!empty) begin // zero word when nothing queued
                    rdata[EVENT_VALID_BIT]   = 1'b1;
                    rdata[EVENT_PRESSED_BIT] = head.pressed;
                    rdata[KEY_IDX_W-1:0]     = head.idx;
                end
            end
            REG_STATUS: begin
                rdata[7:0]            = 8'(count);
                rdata[STATUS_OVF_BIT] = ovf_sticky;
            end
            REG_IRQ_EN: rdata[0] = irq_en;
            default:    rdata = '0;
        endcase
    end

    // read data captured with the ack
    always_ff @(posedge clk) begin
        if (req && !wb_we)
            wb_dat_o <= rdata;
    end

    // ------------------------------------------------------------
    // ack, control registers, irq
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack     <= 1'b0;
            pop_q      <= 1'b0;
            irq_en     <= 1'b0;
            ovf_sticky <= 1'b0;
            irq        <= 1'b0;
        end else begin
            wb_ack <= req; // fixed one clock latency
            pop_q  <= req && !wb_we && (wb_adr == REG_EVENT) && !empty;
            if (wr_stb && (wb_adr == REG_IRQ_EN) && wb_sel[0])
                irq_en <= wb_dat_i[0];
            if (overflow)
                ovf_sticky <= 1'b1; // set wins over a same-clock clear
            else if (ovf_clr)
                ovf_sticky <= 1'b0;
            irq <= irq_en & ~empty; // level, held while events wait
        end
    end

    assign pop = pop_q; // high on the ack clock only

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the key panel testbench with Verilator and run it.
# Exit status is nonzero when the build, the run or the tests fail.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_key_panel \
    -Mdir obj_dir -o tb_key_panel_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_key_panel_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* test/tb_key_panel.sv */
/*
 * key panel testbench with clock, reset, LCG, Wishbone bus tasks,
 * value check and the directed tests
 */

`timescale 1ns/1ps

module tb_key_panel
    import key_panel_pkg::*;
;
    localparam int N_KEYS          = 4;
    localparam int DEBOUNCE_CYCLES = 20;
    localparam int FIFO_DEPTH      = 8;
    localparam int DRIVE_DLY       = 10;  // ns after the rising edge
    localparam int HOLD_CLOCKS     = 40;  // steady level after bouncing
    localparam int ACK_TIMEOUT     = 8;   // clocks
    localparam int IRQ_TIMEOUT     = 100; // clocks

    logic              clk;
    logic              rst_n;
    logic [N_KEYS-1:0] key_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [2:0]        wb_adr;
    logic [31:0]       wb_dat_i;
    logic [3:0]        wb_sel;
    logic [31:0]       wb_dat_o;
    logic              wb_ack;
    logic              irq;

    int                errors       = 0;
    int                tests_run    = 0;
    int                tests_failed = 0;
    int unsigned       lcg_state    = 30364;
    logic [N_KEYS-1:0] exp_toggle   = '0; // toggle model that flips per press

    key_panel_top #(
        .N_KEYS          (N_KEYS),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_n    (key_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_sel   (wb_sel),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .irq      (irq)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk; // 100 ns period

    // ------------------------------------------------------------
    // helpers for time steps, random numbers and checks
    // ------------------------------------------------------------
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY; // inputs change here with outputs settled
        end
    endtask

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'((next_rand() >> 16) % unsigned'(hi - lo + 1));
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("ERR t=%0t: %s, got %h, expected %h", $time, msg, actual, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    // expected EVENT word built from the register map layout
    function automatic logic [31:0] event_word(input logic pressed, input int idx);
        logic [31:0] w;
        w                    = '0;
        w[EVENT_VALID_BIT]   = 1'b1;
        w[EVENT_PRESSED_BIT] = pressed;
        w[KEY_IDX_W-1:0]     = idx[KEY_IDX_W-1:0];
        return w;
    endfunction

    // ------------------------------------------------------------
    // Wishbone classic master
    // ------------------------------------------------------------
    task automatic wb_cycle(input logic we, input logic [2:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        wb_sel   = 4'hf;
        waited   = 0;
        step(1);
        while (!wb_ack && waited < ACK_TIMEOUT) begin // hold until ack
            step(1);
            waited++;
        end
        if (!wb_ack) begin
            $display("timeout: no Wishbone ack within %0d clocks at address %0d",
                     ACK_TIMEOUT, adr);
            errors++;
        end else begin
            check(waited, 0, "Wishbone ack latency in extra clocks");
        end
        rdata  = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        step(1); // idle clock between cycles
        check(32'(wb_ack), 32'h0, "wb_ack held longer than one clock");
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        wb_cycle(1'b0, adr, 32'h0, data);
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, data, unused);
    endtask

    task automatic expect_event(input logic pressed, input int idx);
        logic [31:0] d;
        wb_read(REG_EVENT, d);
        check(d, event_word(pressed, idx), $sformatf("event key %0d pressed %0d", idx, pressed));
    endtask

    task automatic wait_irq(input logic level);
        int waited;
        waited = 0;
        while (irq !== level && waited < IRQ_TIMEOUT) begin
            step(1);
            waited++;
        end
        if (irq !== level) begin
            $display("timeout: irq did not reach %0d within %0d clocks", level, IRQ_TIMEOUT);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // key stimulus with bounces shorter than the settle time
    // ------------------------------------------------------------
    task automatic bounce_key(input int idx, input logic final_n);
        int bounces;
        bounces = rand_range(2, 5);
        for (int b = 0; b < bounces; b++) begin
            key_n[idx] = final_n;
            step(rand_range(1, 10));
            key_n[idx] = ~final_n;
            step(rand_range(1, 10));
        end
        key_n[idx] = final_n;
        step(HOLD_CLOCKS); // long enough to settle and queue
    endtask

    task automatic press_key(input int idx);
        bounce_key(idx, 1'b0);
        exp_toggle[idx] = ~exp_toggle[idx];
    endtask

    task automatic release_key(input int idx);
        bounce_key(idx, 1'b1);
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic reset_defaults();
        int          err_before;
        logic [31:0] d;
        err_before = errors;
        wb_read(REG_STATE, d);
        check(d, 32'h0, "STATE after reset");
        wb_read(REG_TOGGLE, d);
        check(d, 32'h0, "TOGGLE after reset");
        wb_read(REG_STATUS, d);
        check(d & 32'hff, 32'h0, "STATUS count after reset");
        wb_read(REG_EVENT, d);
        check(d, 32'h0, "EVENT with empty queue");
        check(32'(irq), 32'h0, "irq after reset");
        report_test("reset_defaults", err_before);
    endtask

    task automatic bounced_press();
        int          err_before;
        logic [31:0] d;
        err_before = errors;
        press_key(2);
        wb_read(REG_STATE, d);
        check(d, 32'h4, "STATE while key 2 held");
        release_key(2);
        wb_read(REG_STATE, d);
        check(d, 32'h0, "STATE after key 2 released");
        expect_event(1'b1, 2);
        expect_event(1'b0, 2);
        wb_read(REG_EVENT, d);
        check(d, 32'h0, "EVENT after queue drained");
        report_test("bounced_press", err_before);
    endtask

    task automatic short_glitch();
        int          err_before;
        logic [31:0] d;
        err_before = errors;
        key_n[1] = 1'b0;
        step(rand_range(1, 10)); // below DEBOUNCE_CYCLES
        key_n[1] = 1'b1;
        step(HOLD_CLOCKS);
        wb_read(REG_STATE, d);
        check(d, 32'h0, "STATE after glitch");
        wb_read(REG_STATUS, d);
        check(d & 32'hff, 32'h0, "STATUS count after glitch");
        report_test("short_glitch", err_before);
    endtask

    task automatic toggle_flips();
        int          err_before;
        logic [31:0] d;
        logic        start_bit;
        err_before = errors;
        start_bit  = exp_toggle[0];
        press_key(0);
        wb_read(REG_TOGGLE, d);
        check(d, 32'(exp_toggle), "TOGGLE after first press");
        release_key(0);
        press_key(0);
        wb_read(REG_TOGGLE, d);
        check(d, 32'(exp_toggle), "TOGGLE after second press");
        check(32'(d[0]), 32'(start_bit), "TOGGLE bit 0 restored");
        release_key(0);
        for (int i = 0; i < 2; i++) begin
            expect_event(1'b1, 0);
            expect_event(1'b0, 0);
        end
        report_test("toggle_flips", err_before);
    endtask

    task automatic same_clock_keys();
        int          err_before;
        logic [31:0] d;
        err_before = errors;
        key_n[1] = 1'b0; // both in one clock
        key_n[2] = 1'b0;
        exp_toggle[1] = ~exp_toggle[1];
        exp_toggle[2] = ~exp_toggle[2];
        step(HOLD_CLOCKS);
        wb_read(REG_TOGGLE, d);
        check(d, 32'(exp_toggle), "TOGGLE after both keys pressed");
        key_n[1] = 1'b1;
        key_n[2] = 1'b1;
        step(HOLD_CLOCKS);
        expect_event(1'b1, 1); // lower index first
        expect_event(1'b1, 2);
        expect_event(1'b0, 1);
        expect_event(1'b0, 2);
        wb_read(REG_EVENT, d);
        check(d, 32'h0, "EVENT after both keys drained");
        report_test("same_clock_keys", err_before);
    endtask

    task automatic irq_and_overflow();
        int          err_before;
        logic [31:0] d;
        logic [31:0] ovf;
        err_before = errors;
        ovf        = 32'h1 << STATUS_OVF_BIT;
        wb_write(REG_IRQ_EN, 32'h1);
        wb_read(REG_IRQ_EN, d);
        check(d, 32'h1, "IRQ_EN readback");
        check(32'(irq), 32'h0, "irq with empty queue");
        press_key(3);
        wait_irq(1'b1);
        release_key(3);
        // 12 events make 8 queued, 2 pending and 2 lost
        for (int i = 0; i < 5; i++) begin
            press_key(3);
            release_key(3);
        end
        wb_read(REG_STATUS, d);
        check(d, 32'(FIFO_DEPTH) | ovf, "STATUS full with overflow");
        wb_write(REG_STATUS, ovf);
        wb_read(REG_STATUS, d);
        check(d, 32'(FIFO_DEPTH), "STATUS after overflow clear");
        for (int i = 0; i < 5; i++) begin // pending pair refills the queue
            expect_event(1'b1, 3);
            expect_event(1'b0, 3);
        end
        wb_read(REG_EVENT, d);
        check(d, 32'h0, "EVENT after drain");
        wait_irq(1'b0);
        report_test("irq_and_overflow", err_before);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        rst_n    = 1'b0;
        key_n    = '1; // idle lines high
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        wb_sel   = '0;
        repeat (16) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        step(2);

        reset_defaults();
        bounced_press();
        short_glitch();
        toggle_flips();
        same_clock_keys();
        irq_and_overflow();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
